// File: flist.f
icache_pkg.sv
refill_if.sv
sync_ram.sv
refill_unit.sv
icache_ctrl.sv
icache_top.sv
icache_asserts.sv
tb_icache.sv

// File: tb_icache.sv
/*
 * Testbench for the instruction cache. Drives CPU fetches against a
 * behavioral AXI memory with random back-pressure and checks the data,
 * the refill count per fetch and the hit latency.
 */
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam int NUM_RANDOM = 40;
    localparam int NUM_REQ = 1 + 4 + 3 + 1 + NUM_RANDOM + 2;

    logic clk;
    logic rst;
    addr_t addr;
    logic read;
    logic flush;
    fetch_t rdata;
    logic stall;
    logic [3:0] arid;
    addr_t araddr;
    logic [3:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic arvalid;
    logic arready;
    logic [31:0] rdata_axi;
    logic [1:0] rresp;
    logic rlast;
    logic rvalid;
    logic rready;

    int seed = 59;
    int err_count = 0;
    int ar_count = 0;
    int pass_count = 0;
    int fail_count = 0;

    icache_top UUT (.*);

    function automatic logic [31:0] mem_word(input addr_t a);
        return a ^ 32'h5A3C_96E1;
    endfunction

    // Two words starting at the 8-byte aligned address, lower word first
    function automatic fetch_t expected_fetch(input addr_t a);
        addr_t base;
        base = {a[ADDR_LEN-1:3], 3'b000};
        return {mem_word(base + 4), mem_word(base)};
    endfunction

    function automatic int total_errors();
        return err_count + UUT.u_asserts.fail_count;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && read && !stall) begin
            assert (rdata == expected_fetch(addr)) else begin
                err_count++;
                $display("error: t=%0t rdata expected %h got %h",
                         $time, expected_fetch(addr), rdata);
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && arvalid && arready) begin
            ar_count++;
            assert (araddr == {addr[ADDR_LEN-1:OFFSET_LEN], {OFFSET_LEN{1'b0}}}) else begin
                err_count++;
                $display("error: t=%0t araddr expected %h got %h", $time,
                         {addr[ADDR_LEN-1:OFFSET_LEN], {OFFSET_LEN{1'b0}}}, araddr);
            end
        end
    end

    // AXI memory with random arready delay and random gaps between beats
    initial begin : axi_memory
        addr_t base;
        int beat;
        arready = 1'b0;
        rdata_axi = '0;
        rresp = 2'b00;
        rlast = 1'b0;
        rvalid = 1'b0;
        forever begin
            @(posedge clk);
            if (arvalid) begin
                repeat ({$random(seed)} % 4) @(posedge clk);
                #1;
                arready = 1'b1;
                base = araddr;
                @(posedge clk);
                #1;
                arready = 1'b0;
                beat = 0;
                while (beat < LINE_BEATS) begin
                    if ({$random(seed)} % 4 == 0) begin
                        rvalid = 1'b0;
                        rlast = 1'b0;
                    end else begin
                        rvalid = 1'b1;
                        rdata_axi = mem_word(base + 4 * beat);
                        rlast = (beat == LINE_BEATS - 1);
                    end
                    @(posedge clk);
                    if (rvalid && rready) begin
                        beat++;
                    end
                    #1;
                end
                rvalid = 1'b0;
                rlast = 1'b0;
            end
        end
    end

    // Called and returns one time unit after an edge
    task automatic fetch(input addr_t a, output int ars, output int waits);
        int ar_start;
        ar_start = ar_count;
        waits = 0;
        addr = a;
        read = 1'b1;
        @(posedge clk);
        while (stall) begin
            waits++;
            @(posedge clk);
        end
        #1;
        read = 1'b0;
        ars = ar_count - ar_start;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            err_count++;
            $display("error: t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (total_errors() == errs_before) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: FAILED", name);
        end
    endtask

    initial begin : watchdog
        repeat (NUM_REQ * 60 + 200) @(posedge clk);
        $display("watchdog expired, a fetch did not complete in time");
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        int ars;
        int waits;
        int errs;
        addr_t a;
        index_t idx;
        logic resident;
        logic res_valid [NUM_LINES];
        tag_t res_tag [NUM_LINES];

        rst = 1'b1;
        addr = '0;
        read = 1'b0;
        flush = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        errs = total_errors();
        fetch(32'h0000_1010, ars, waits);
        check_count("ar_count", 1, ars);
        end_test("cold miss", errs);

        errs = total_errors();
        for (int i = 0; i < 4; i++) begin
            fetch(32'h0000_1000 + ((i + 3) % 4) * 8, ars, waits);
            check_count("ar_count", 0, ars);
            check_count("stall_cycles", 1, waits);
        end
        end_test("hits on filled line", errs);

        errs = total_errors();
        fetch(32'h0000_10A0, ars, waits);
        check_count("ar_count", 1, ars);
        fetch(32'h0000_18A0, ars, waits);
        check_count("ar_count", 1, ars);
        fetch(32'h0000_10A0, ars, waits);
        check_count("ar_count", 1, ars);
        end_test("same index eviction", errs);

        errs = total_errors();
        pulse_flush();
        fetch(32'h0000_1008, ars, waits);
        check_count("ar_count", 1, ars);
        end_test("refill after flush", errs);

        errs = total_errors();
        pulse_flush();
        for (int i = 0; i < NUM_LINES; i++) begin
            res_valid[i] = 1'b0;
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = 32'h0002_0000 + ({$random(seed)} % 512) * 8;
            idx = a[OFFSET_LEN +: INDEX_LEN];
            resident = res_valid[idx] && (res_tag[idx] == a[ADDR_LEN-1 -: TAG_LEN]);
            fetch(a, ars, waits);
            check_count("ar_count", resident ? 0 : 1, ars);
            res_valid[idx] = 1'b1;
            res_tag[idx] = a[ADDR_LEN-1 -: TAG_LEN];
        end
        end_test("random fetches with back-pressure", errs);

        // The refilled line is dropped, so the stalled fetch refills twice
        errs = total_errors();
        fork
            fetch(32'h0004_0040, ars, waits);
            begin
                while (!arvalid) begin
                    @(posedge clk);
                end
                #1;
                pulse_flush();
            end
        join
        check_count("ar_count", 2, ars);
        fetch(32'h0004_0048, ars, waits);
        check_count("ar_count", 0, ars);
        end_test("flush during refill", errs);

        $display("tests passed %0d, failed %0d, errors %0d",
                 pass_count, fail_count, total_errors());
        if (fail_count == 0 && total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: icache_asserts.sv
/*
 * AXI read protocol and stall checks for the instruction cache.
 * Bound into icache_top by the bind at the end of this file.
 */
`default_nettype none

module icache_asserts import icache_pkg::*; (
    input wire        clk,
    input wire        rst,
    input wire        stall,
    input wire  [3:0] arid,
    input addr_t      araddr,
    input wire  [3:0] arlen,
    input wire  [2:0] arsize,
    input wire  [1:0] arburst,
    input wire        arvalid,
    input wire        arready,
    input wire        rlast,
    input wire        rvalid,
    input wire        rready
);

    int fail_count = 0;
    logic outstanding;

    // Burst accepted but last beat not yet seen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (arvalid && arready) begin
            outstanding <= 1'b1;
        end else if (rvalid && rready && rlast) begin
            outstanding <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
        else begin
            fail_count++;
            $error("arvalid dropped or araddr changed before arready");
        end

    ar_aligned: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> (araddr[4:0] == 5'd0))
        else begin
            fail_count++;
            $error("araddr is not aligned to a 32-byte line");
        end

    ar_shape: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> (arlen == 4'd7 && arsize == 3'd2 && arburst == 2'b01 && arid == 4'd0))
        else begin
            fail_count++;
            $error("burst is not an 8-beat INCR of 4 bytes with ID 0");
        end

    r_outstanding: assert property (@(posedge clk) disable iff (rst)
        rready |-> outstanding)
        else begin
            fail_count++;
            $error("rready high with no burst outstanding");
        end

    stall_on_ar: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> stall)
        else begin
            fail_count++;
            $error("stall low while a refill address is pending");
        end

endmodule

bind icache_top icache_asserts u_asserts (.*);

`default_nettype wire

// File: icache_top.sv
/*
 * Instruction cache top level. CPU fetch port on one side and the AXI3
 * read address and data channels on the other.
 */
`default_nettype none

module icache_top import icache_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  addr_t       addr,
    input  wire         read,
    input  wire         flush,
    output fetch_t      rdata,
    output logic        stall,
    output logic [3:0]  arid,
    output addr_t       araddr,
    output logic [3:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic        arvalid,
    input  wire         arready,
    input  wire  [31:0] rdata_axi,
    input  wire  [1:0]  rresp,
    input  wire         rlast,
    input  wire         rvalid,
    output logic        rready
);

    tag_t   tag_rd;
    tag_t   tag_wr;
    line_t  line_rd;
    line_t  line_wr;
    index_t ram_index;
    logic   ram_write;

    refill_if rf ();

    icache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .read      (read),
        .flush     (flush),
        .rdata     (rdata),
        .stall     (stall),
        .tag_rd    (tag_rd),
        .line_rd   (line_rd),
        .ram_index (ram_index),
        .ram_write (ram_write),
        .tag_wr    (tag_wr),
        .line_wr   (line_wr),
        .rf        (rf.ctrl)
    );

    sync_ram #(.T(tag_t), .DEPTH(NUM_LINES)) u_tag_ram (
        .clk   (clk),
        .write (ram_write),
        .addr  (ram_index),
        .wdata (tag_wr),
        .rdata (tag_rd)
    );

    sync_ram #(.T(line_t), .DEPTH(NUM_LINES)) u_line_ram (
        .clk   (clk),
        .write (ram_write),
        .addr  (ram_index),
        .wdata (line_wr),
        .rdata (line_rd)
    );

    // rresp is not inspected, refills assume OKAY
    refill_unit u_refill (
        .clk       (clk),
        .rst       (rst),
        .rf        (rf.unit),
        .arid      (arid),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arvalid   (arvalid),
        .arready   (arready),
        .beat_data (rdata_axi),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

endmodule

`default_nettype wire

// File: icache_ctrl.sv
/*
 * Lookup and refill control for the direct-mapped instruction cache.
 * Holds the valid bits, decides hit or miss against the tag RAM output
 * and picks the 64-bit fetch slot from the line RAM output.
 */
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  addr_t   addr,
    input  wire     read,
    input  wire     flush,
    output fetch_t  rdata,
    output logic    stall,
    input  tag_t    tag_rd,
    input  line_t   line_rd,
    output index_t  ram_index,
    output logic    ram_write,
    output tag_t    tag_wr,
    output line_t   line_wr,
    refill_if.ctrl  rf
);

    typedef enum logic [2:0] {
        IDLE,
        MISS,
        REFILL,
        WRITE,
        LOOKUP
    } state_t;

    state_t state;
    addr_t addr_q;
    logic [NUM_LINES-1:0] valid;
    logic flush_pend;
    line_t line_buf;

    index_t idx_q;
    tag_t tag_q;
    logic [SLOT_LEN-1:0] slot_q;
    logic [SLOT_LEN:0] word_lo;
    logic [SLOT_LEN:0] word_hi;
    logic hit;
    logic lookup_state;

    assign idx_q  = addr_q[OFFSET_LEN +: INDEX_LEN];
    assign tag_q  = addr_q[ADDR_LEN-1 -: TAG_LEN];
    assign slot_q = addr_q[OFFSET_LEN-1 -: SLOT_LEN];

    // RAM output belongs to addr_q, so the live address must still match
    assign hit = valid[idx_q] && (tag_rd == tag_q) && (addr_q == addr);
    assign lookup_state = (state == IDLE) || (state == LOOKUP);

    assign word_lo = {slot_q, 1'b0};
    assign word_hi = {slot_q, 1'b1};
    assign rdata = {line_rd[word_hi], line_rd[word_lo]};

    assign stall = !(lookup_state && read && hit);

    assign ram_index = (state == WRITE) ? idx_q : addr[OFFSET_LEN +: INDEX_LEN];
    assign ram_write = (state == WRITE);
    assign tag_wr = tag_q;
    assign line_wr = line_buf;

    assign rf.start = (state == MISS);
    assign rf.line_addr = addr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            addr_q <= '0;
        end else begin
            addr_q <= addr;
            case (state)
                IDLE: begin
                    if (read && addr_q == addr && !hit) begin
                        state <= MISS;
                    end
                end
                MISS: state <= REFILL;
                REFILL: begin
                    if (rf.done) begin
                        state <= WRITE;
                    end
                end
                WRITE: state <= LOOKUP;
                LOOKUP: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Valid bits; a flush seen during a refill also kills the new line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
            flush_pend <= 1'b0;
        end else if (state == WRITE) begin
            flush_pend <= 1'b0;
            if (flush_pend || flush) begin
                valid <= '0;
            end else begin
                valid[idx_q] <= 1'b1;
            end
        end else if (flush) begin
            if (lookup_state) begin
                valid <= '0;
            end else begin
                flush_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rf.done) begin
            line_buf <= rf.line;
        end
    end

endmodule

`default_nettype wire

// File: refill_unit.sv
/*
 * AXI3 read master for line refills. One start pulse issues a single
 * INCR burst for the aligned line; beats are packed into a line and
 * handed back with a one-cycle done pulse.
 */
`default_nettype none

module refill_unit import icache_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    refill_if.unit      rf,
    output logic [3:0]  arid,
    output addr_t       araddr,
    output logic [3:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic        arvalid,
    input  wire         arready,
    input  wire  [31:0] beat_data,
    input  wire         rlast,
    input  wire         rvalid,
    output logic        rready
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        BEATS
    } state_t;

    state_t state;
    logic [$clog2(LINE_BEATS)-1:0] beat_cnt;
    logic done_q;
    line_t line_q;

    // Fixed burst shape, address comes straight from the controller
    assign arid    = '0;
    assign araddr  = {rf.line_addr[ADDR_LEN-1:OFFSET_LEN], {OFFSET_LEN{1'b0}}};
    assign arlen   = AXI_LEN;
    assign arsize  = AXI_SIZE;
    assign arburst = AXI_INCR;
    assign arvalid = (state == ADDR);
    assign rready  = (state == BEATS);

    assign rf.done = done_q;
    assign rf.line = line_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            beat_cnt <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (rf.start) begin
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    beat_cnt <= '0;
                    if (arready) begin
                        state <= BEATS;
                    end
                end
                BEATS: begin
                    if (rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rlast) begin
                            state <= IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Beat payload, held until the next refill overwrites it
    always_ff @(posedge clk) begin
        if (state == BEATS && rvalid) begin
            line_q[beat_cnt] <= beat_data;
        end
    end

endmodule

`default_nettype wire

// File: sync_ram.sv
/*
 * Single-port RAM with a registered read port.
 * A write in the same cycle is returned on rdata at the next edge.
 */
`default_nettype none

module sync_ram import icache_pkg::*; #(
    parameter type T = logic,
    parameter int DEPTH = NUM_LINES
) (
    input  wire    clk,
    input  wire    write,
    input  index_t addr,
    input  wire T  wdata,
    output T       rdata
);

    T mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= wdata;
            rdata <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: refill_if.sv
/*
 * Link between the cache controller and the AXI refill unit.
 * The controller pulses start with a line address and waits for done.
 */
`default_nettype none

interface refill_if import icache_pkg::*; ();

    logic  start;
    addr_t line_addr;
    logic  done;
    line_t line;

    modport ctrl (
        output start,
        output line_addr,
        input  done,
        input  line
    );

    modport unit (
        input  start,
        input  line_addr,
        output done,
        output line
    );

endinterface

`default_nettype wire

// File: icache_pkg.sv
/*
 * Shared widths, AXI constants and payload types for the instruction cache.
 * Imported by every RTL block and by the testbench.
 */
`default_nettype none

package icache_pkg;

    // Address and line geometry
    localparam int ADDR_LEN   = 32;
    localparam int FETCH_BITS = 64;
    localparam int LINE_BEATS = 8;
    localparam int LINE_BITS  = LINE_BEATS * 32;
    localparam int OFFSET_LEN = $clog2(LINE_BITS / 8);
    localparam int SLOT_LEN   = $clog2(LINE_BITS / FETCH_BITS);
    localparam int INDEX_LEN  = 6;
    localparam int NUM_LINES  = 1 << INDEX_LEN;
    localparam int TAG_LEN    = ADDR_LEN - INDEX_LEN - OFFSET_LEN;

    // AXI3 read burst fields
    localparam logic [3:0] AXI_LEN  = 4'(LINE_BEATS - 1);
    localparam logic [2:0] AXI_SIZE = 3'd2;
    localparam logic [1:0] AXI_INCR = 2'b01;

    typedef logic [TAG_LEN-1:0] tag_t;
    typedef logic [INDEX_LEN-1:0] index_t;

    // Word 0 holds the lowest address of the line
    typedef logic [LINE_BEATS-1:0][31:0] line_t;

    typedef logic [FETCH_BITS-1:0] fetch_t;
    typedef logic [ADDR_LEN-1:0] addr_t;

endpackage

`default_nettype wire
